/* bench/cache_subsystem_asserts.sv */
`timescale 1ns/1ps

module cache_subsystem_asserts (
    input logic                clk,
    input logic                arst_n,
    input logic                mem_valid,
    input cache_pkg::mem_req_t mem_req,
    input logic                mem_addr_ok,
    input logic                mem_data_ok,
    input logic                ic_data_ok,
    input logic                dc_data_ok
);

    logic pending_q;   // addr_ok seen, data_ok not yet

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= 1'b0;
        end else if (mem_valid && mem_addr_ok) begin
            pending_q <= 1'b1;
        end else if (mem_data_ok) begin
            pending_q <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_valid && !mem_addr_ok |=> mem_valid && $stable(mem_req))
        else $error("memory request dropped or changed before addr_ok");

    // each response goes to exactly one cache
    data_ok_single: assert property (@(posedge clk) disable iff (!arst_n)
        mem_data_ok |-> (ic_data_ok ^ dc_data_ok))
        else $error("data_ok not routed to exactly one cache");

    grant_locked: assert property (@(posedge clk) disable iff (!arst_n)
        pending_q |-> !mem_valid)
        else $error("arbiter regranted while a transaction was outstanding");

endmodule

bind mem_arbiter cache_subsystem_asserts cache_subsystem_asserts_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .mem_valid   (mem_valid),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok),
    .ic_data_ok  (ic_data_ok),
    .dc_data_ok  (dc_data_ok)
);

/* bench/tb_cache_subsystem.sv */
`timescale 1ns/1ps

module tb_cache_subsystem;
    import cache_pkg::*;

    localparam int TIMEOUT = 100;   // cycles per wait

    logic     clk;
    logic     arst_n;
    logic     fetch_valid;
    word_t    fetch_addr;
    logic     fetch_ready;
    logic     fetch_resp_valid;
    word_t    fetch_data;
    logic     lsu_valid;
    lsu_req_t lsu_req;
    logic     lsu_ready;
    logic     lsu_resp_valid;
    word_t    lsu_rdata;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_addr_ok;
    logic     mem_data_ok;
    line_t    mem_rdata;

    integer   seed = 32'hd20c;
    int       errors = 0;
    int       read_count = 0;
    int       write_count = 0;
    mem_req_t last_write;
    word_t    read_log [$];
    word_t    mem_array [64];   // what the DUT sees
    word_t    model [64];       // expected contents

    cache_subsystem cache_subsystem_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic word_t strobe_merge(word_t old_word, word_t new_word, logic [3:0] strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic lsu_req_t make_req(lsu_op_e op, word_t addr, word_t data,
                                          logic [3:0] strb);
        lsu_req_t req;
        req.op    = op;
        req.addr  = addr;
        req.wdata = data;
        req.wstrb = strb;
        return req;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_line_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_state_bool(input string name, input bit expected, input bit actual);
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %0b actual %0b", $time, name, expected, actual);
        end
    endtask

    // memory port, one transaction at a time
    always begin : memory_model
        mem_req_t req;
        int       addr_delay;
        int       data_delay;
        int       base;
        @(negedge clk);
        if (arst_n === 1'b1 && mem_valid === 1'b1) begin
            req        = mem_req;
            base       = req.addr[7:2];
            addr_delay = {$random(seed)} % 4;
            data_delay = {$random(seed)} % 4 + 1;
            repeat (addr_delay) @(negedge clk);
            mem_addr_ok = 1'b1;
            if (req.op == MEM_READ_LINE) begin
                read_count++;
                read_log.push_back(req.addr);
            end else begin
                write_count++;
                last_write = req;
            end
            @(negedge clk);
            mem_addr_ok = 1'b0;
            repeat (data_delay - 1) @(negedge clk);
            if (req.op == MEM_WRITE_WORD) begin
                mem_array[base] = strobe_merge(mem_array[base], req.wdata, req.wstrb);
            end else begin
                mem_rdata = {mem_array[base+3], mem_array[base+2],
                             mem_array[base+1], mem_array[base]};
            end
            mem_data_ok = 1'b1;
            @(negedge clk);
            mem_data_ok = 1'b0;
        end
    end

    // one request on either port, new_reads < 0 skips the read count
    task automatic access(input bit fetch, input lsu_req_t req, input int new_reads);
        string port;
        int    waited;
        int    reads;
        int    writes;
        if (fetch) begin
            port = "fetch";
        end else begin
            port = "lsu";
        end
        reads  = read_count;
        writes = write_count;
        waited = 0;
        while ((fetch ? fetch_ready : lsu_ready) !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if ((fetch ? fetch_ready : lsu_ready) !== 1'b1) begin
            errors++;
            $display("%s port never became ready for address %h", port, req.addr);
            return;
        end
        if (fetch) begin
            fetch_valid = 1'b1;
            fetch_addr  = req.addr;
        end else begin
            lsu_valid = 1'b1;
            lsu_req   = req;
        end
        @(negedge clk);
        if (fetch) begin
            fetch_valid = 1'b0;
        end else begin
            lsu_valid = 1'b0;
        end
        waited = 1;   // cycles since the accept cycle
        while ((fetch ? fetch_resp_valid : lsu_resp_valid) !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if ((fetch ? fetch_resp_valid : lsu_resp_valid) !== 1'b1) begin
            errors++;
            $display("no %s response for address %h in %0d cycles", port, req.addr, TIMEOUT);
            return;
        end
        if (req.op == LSU_STORE) begin
            model[req.addr[7:2]] = strobe_merge(model[req.addr[7:2]], req.wdata, req.wstrb);
            check_line_count("memory write requests", writes + 1, write_count);
            check_word("mem_req.addr", req.addr, last_write.addr);
            check_word("mem_req.wdata", req.wdata, last_write.wdata);
            check_word("mem_req.wstrb", word_t'(req.wstrb), word_t'(last_write.wstrb));
        end else begin
            if (fetch) begin
                check_word("fetch_data", model[req.addr[7:2]], fetch_data);
            end else begin
                check_word("lsu_rdata", model[req.addr[7:2]], lsu_rdata);
            end
            if (new_reads == 0) begin
                check_cycles({port, " hit latency"}, 2, waited);
            end
        end
        if (new_reads >= 0) begin
            check_line_count("memory line reads", reads + new_reads, read_count);
        end
    endtask

    task automatic test_fetch_miss_hit();
        access(1'b1, make_req(LSU_LOAD, 32'h20, '0, '0), 1);
        access(1'b1, make_req(LSU_LOAD, 32'h24, '0, '0), 0);   // same line
    endtask

    task automatic test_load_miss_hit();
        access(1'b0, make_req(LSU_LOAD, 32'h34, '0, '0), 1);
        access(1'b0, make_req(LSU_LOAD, 32'h38, '0, '0), 0);
    endtask

    task automatic test_store_hit();
        access(1'b0, make_req(LSU_STORE, 32'h38, $random(seed), 4'b0101), 0);
        access(1'b0, make_req(LSU_STORE, 32'h34, $random(seed), 4'b1000), 0);
        access(1'b0, make_req(LSU_LOAD, 32'h38, '0, '0), 0);
        access(1'b0, make_req(LSU_LOAD, 32'h34, '0, '0), 0);
    endtask

    task automatic test_store_miss();
        access(1'b0, make_req(LSU_STORE, 32'h84, $random(seed), 4'b0011), 0);
        access(1'b0, make_req(LSU_LOAD, 32'h84, '0, '0), 1);   // line was not allocated
    endtask

    task automatic test_conflict();
        for (int i = 0; i < 4; i++) begin
            access(1'b0, make_req(LSU_LOAD, (i % 2) ? 32'hc8 : 32'h48, '0, '0), 1);
        end
    endtask

    task automatic test_concurrent_miss();
        int reads;
        reads = read_count;
        read_log.delete();
        fork
            access(1'b1, make_req(LSU_LOAD, 32'h60, '0, '0), -1);
            access(1'b0, make_req(LSU_LOAD, 32'h10, '0, '0), -1);
        join
        check_line_count("memory line reads", reads + 2, read_count);
        if (read_log.size() == 2) begin
            check_word("first line read addr", 32'h10, read_log[0]);   // dcache wins
            check_word("second line read addr", 32'h60, read_log[1]);
        end
    endtask

    initial begin
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        lsu_valid   = 1'b0;
        lsu_req     = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        arst_n      = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_array[i] = $random(seed);
            model[i]     = mem_array[i];
        end
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        check_state_bool("fetch_ready", 1'b1, fetch_ready);
        check_state_bool("lsu_ready", 1'b1, lsu_ready);
        check_state_bool("fetch_resp_valid", 1'b0, fetch_resp_valid);
        check_state_bool("lsu_resp_valid", 1'b0, lsu_resp_valid);
        check_state_bool("mem_valid", 1'b0, mem_valid);
        test_fetch_miss_hit();
        test_load_miss_hit();
        test_store_hit();
        test_store_miss();
        test_conflict();
        test_concurrent_miss();
        $display("errors: %0d, line reads: %0d, word writes: %0d",
                 errors, read_count, write_count);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH  = 2;
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;
    localparam int NUM_LINES    = 1 << INDEX_WIDTH;

    typedef logic [31:0]               word_t;
    typedef logic [32*LINE_WORDS-1:0]  line_t;    // word 0 in the low bits
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [INDEX_WIDTH-1:0]    index_t;
    typedef logic [OFFSET_WIDTH-1:0]   offset_t;

    typedef enum logic {
        LSU_LOAD,
        LSU_STORE
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e    op;
        word_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
    } lsu_req_t;

    typedef enum logic {
        MEM_READ_LINE,
        MEM_WRITE_WORD
    } mem_op_e;

    typedef struct packed {
        mem_op_e    op;
        word_t      addr;    // line aligned for reads
        word_t      wdata;
        logic [3:0] wstrb;   // zero for reads
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        WRITE_REQ,
        WRITE_WAIT
    } cache_state_e;

    function automatic tag_t addr_tag(word_t addr);
        return addr[31 -: TAG_WIDTH];
    endfunction

    function automatic index_t addr_index(word_t addr);
        return addr[2+OFFSET_WIDTH +: INDEX_WIDTH];
    endfunction

    function automatic offset_t addr_offset(word_t addr);
        return addr[2 +: OFFSET_WIDTH];
    endfunction

    function automatic word_t line_base(word_t addr);
        return {addr[31:2+OFFSET_WIDTH], {(2+OFFSET_WIDTH){1'b0}}};
    endfunction

    function automatic word_t line_word(line_t line, offset_t off);
        return line[32*off +: 32];
    endfunction

endpackage

/* hdl/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                fetch_valid,
    input  cache_pkg::word_t    fetch_addr,
    output logic                fetch_ready,
    output logic                fetch_resp_valid,
    output cache_pkg::word_t    fetch_data,

    input  logic                lsu_valid,
    input  cache_pkg::lsu_req_t lsu_req,
    output logic                lsu_ready,
    output logic                lsu_resp_valid,
    output cache_pkg::word_t    lsu_rdata,

    output logic                mem_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    input  cache_pkg::line_t    mem_rdata
);
    import cache_pkg::*;

    logic     ic_mem_valid;
    mem_req_t ic_mem_req;
    logic     ic_mem_addr_ok;
    logic     ic_mem_data_ok;
    line_t    ic_mem_rdata;

    logic     dc_mem_valid;
    mem_req_t dc_mem_req;
    logic     dc_mem_addr_ok;
    logic     dc_mem_data_ok;
    line_t    dc_mem_rdata;

    icache icache_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_valid      (fetch_valid),
        .fetch_addr       (fetch_addr),
        .fetch_ready      (fetch_ready),
        .fetch_resp_valid (fetch_resp_valid),
        .fetch_data       (fetch_data),
        .mem_valid        (ic_mem_valid),
        .mem_req          (ic_mem_req),
        .mem_addr_ok      (ic_mem_addr_ok),
        .mem_data_ok      (ic_mem_data_ok),
        .mem_rdata        (ic_mem_rdata)
    );

    dcache dcache_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .lsu_valid      (lsu_valid),
        .lsu_req        (lsu_req),
        .lsu_ready      (lsu_ready),
        .lsu_resp_valid (lsu_resp_valid),
        .lsu_rdata      (lsu_rdata),
        .mem_valid      (dc_mem_valid),
        .mem_req        (dc_mem_req),
        .mem_addr_ok    (dc_mem_addr_ok),
        .mem_data_ok    (dc_mem_data_ok),
        .mem_rdata      (dc_mem_rdata)
    );

    mem_arbiter mem_arbiter_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .ic_valid    (ic_mem_valid),
        .ic_req      (ic_mem_req),
        .ic_addr_ok  (ic_mem_addr_ok),
        .ic_data_ok  (ic_mem_data_ok),
        .ic_rdata    (ic_mem_rdata),
        .dc_valid    (dc_mem_valid),
        .dc_req      (dc_mem_req),
        .dc_addr_ok  (dc_mem_addr_ok),
        .dc_data_ok  (dc_mem_data_ok),
        .dc_rdata    (dc_mem_rdata),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* hdl/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                lsu_valid,
    input  cache_pkg::lsu_req_t lsu_req,
    output logic                lsu_ready,
    output logic                lsu_resp_valid,
    output cache_pkg::word_t    lsu_rdata,

    output logic                mem_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    input  cache_pkg::line_t    mem_rdata
);
    import cache_pkg::*;

    cache_state_e         state_q;
    lsu_req_t             req_q;
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q [NUM_LINES];
    line_t                line_q [NUM_LINES];

    index_t  idx;
    offset_t off;
    logic    hit;
    logic    load_hit;
    logic    refill_done;
    logic    store_merge;
    word_t   merged_word;
    line_t   merged_line;

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, logic [3:0] strb);
        word_t result;
        int    b;
        result = old_word;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign idx = addr_index(req_q.addr);
    assign off = addr_offset(req_q.addr);
    assign hit = valid_q[idx] && (tag_q[idx] == addr_tag(req_q.addr));

    assign load_hit    = (state_q == LOOKUP) && (req_q.op == LSU_LOAD) && hit;
    assign refill_done = (state_q == REFILL_WAIT) && mem_data_ok;
    // arrays are untouched since lookup, so hit still holds here
    assign store_merge = (state_q == WRITE_REQ) && mem_addr_ok && hit;

    assign merged_word = merge_bytes(line_word(line_q[idx], off), req_q.wdata, req_q.wstrb);

    always_comb begin
        merged_line              = line_q[idx];
        merged_line[32*off +: 32] = merged_word;
    end

    assign lsu_ready = (state_q == IDLE);
    assign mem_valid = (state_q == REFILL_REQ) || (state_q == WRITE_REQ);

    always_comb begin
        if (state_q == WRITE_REQ) begin
            mem_req = '{
                op:    MEM_WRITE_WORD,
                addr:  req_q.addr,
                wdata: req_q.wdata,
                wstrb: req_q.wstrb
            };
        end else begin
            mem_req = '{
                op:    MEM_READ_LINE,
                addr:  line_base(req_q.addr),
                wdata: 32'h0,
                wstrb: 4'h0
            };
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q        <= IDLE;
            lsu_resp_valid <= 1'b0;
            valid_q        <= '0;
        end else begin
            lsu_resp_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (lsu_valid) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (req_q.op == LSU_STORE) begin
                        state_q <= WRITE_REQ;   // write-through, hit or miss
                    end else if (hit) begin
                        lsu_resp_valid <= 1'b1;
                        state_q        <= IDLE;
                    end else begin
                        state_q <= REFILL_REQ;
                    end
                end
                REFILL_REQ: begin
                    if (mem_addr_ok) begin
                        state_q <= REFILL_WAIT;
                    end
                end
                REFILL_WAIT: begin
                    if (mem_data_ok) begin
                        lsu_resp_valid <= 1'b1;
                        valid_q[idx]   <= 1'b1;
                        state_q        <= IDLE;
                    end
                end
                WRITE_REQ: begin
                    if (mem_addr_ok) begin
                        state_q <= WRITE_WAIT;
                    end
                end
                WRITE_WAIT: begin
                    if (mem_data_ok) begin
                        lsu_resp_valid <= 1'b1;
                        state_q        <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_valid && lsu_ready) begin
            req_q <= lsu_req;
        end
        if (load_hit) begin
            lsu_rdata <= line_word(line_q[idx], off);
        end
        if (refill_done) begin
            tag_q[idx]  <= addr_tag(req_q.addr);
            line_q[idx] <= mem_rdata;
            lsu_rdata   <= line_word(mem_rdata, off);
        end else if (store_merge) begin
            line_q[idx] <= merged_line;   // no allocate on a store miss
        end
    end

endmodule

/* hdl/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                fetch_valid,
    input  cache_pkg::word_t    fetch_addr,
    output logic                fetch_ready,
    output logic                fetch_resp_valid,
    output cache_pkg::word_t    fetch_data,

    output logic                mem_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    input  cache_pkg::line_t    mem_rdata
);
    import cache_pkg::*;

    cache_state_e         state_q;
    word_t                addr_q;
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q [NUM_LINES];
    line_t                line_q [NUM_LINES];

    index_t  idx;
    offset_t off;
    logic    hit;
    logic    lookup_hit;
    logic    refill_done;

    assign idx = addr_index(addr_q);
    assign off = addr_offset(addr_q);
    assign hit = valid_q[idx] && (tag_q[idx] == addr_tag(addr_q));

    assign lookup_hit  = (state_q == LOOKUP) && hit;
    assign refill_done = (state_q == REFILL_WAIT) && mem_data_ok;

    assign fetch_ready = (state_q == IDLE);   // one fetch in flight
    assign mem_valid   = (state_q == REFILL_REQ);
    assign mem_req     = '{
        op:    MEM_READ_LINE,
        addr:  line_base(addr_q),
        wdata: 32'h0,
        wstrb: 4'h0
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q          <= IDLE;
            fetch_resp_valid <= 1'b0;
            valid_q          <= '0;
        end else begin
            fetch_resp_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (fetch_valid) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        fetch_resp_valid <= 1'b1;
                        state_q          <= IDLE;
                    end else begin
                        state_q <= REFILL_REQ;
                    end
                end
                REFILL_REQ: begin
                    if (mem_addr_ok) begin
                        state_q <= REFILL_WAIT;
                    end
                end
                REFILL_WAIT: begin
                    if (mem_data_ok) begin
                        fetch_resp_valid <= 1'b1;
                        valid_q[idx]     <= 1'b1;
                        state_q          <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            addr_q <= fetch_addr;
        end
        if (lookup_hit) begin
            fetch_data <= line_word(line_q[idx], off);
        end
        if (refill_done) begin
            tag_q[idx]  <= addr_tag(addr_q);
            line_q[idx] <= mem_rdata;
            fetch_data  <= line_word(mem_rdata, off);   // critical word from the fill
        end
    end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                ic_valid,
    input  cache_pkg::mem_req_t ic_req,
    output logic                ic_addr_ok,
    output logic                ic_data_ok,
    output cache_pkg::line_t    ic_rdata,

    input  logic                dc_valid,
    input  cache_pkg::mem_req_t dc_req,
    output logic                dc_addr_ok,
    output logic                dc_data_ok,
    output cache_pkg::line_t    dc_rdata,

    output logic                mem_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    input  cache_pkg::line_t    mem_rdata
);

    logic busy_q;
    logic owner_dc_q;   // high when dcache owns the port
    logic sel_dc;

    // when idle the data cache wins, once granted the owner is locked
    assign sel_dc = busy_q ? owner_dc_q : dc_valid;

    assign mem_valid = sel_dc ? dc_valid : ic_valid;
    assign mem_req   = sel_dc ? dc_req : ic_req;

    assign ic_addr_ok = mem_addr_ok && !sel_dc;
    assign dc_addr_ok = mem_addr_ok && sel_dc;

    assign ic_data_ok = mem_data_ok && busy_q && !owner_dc_q;
    assign dc_data_ok = mem_data_ok && busy_q && owner_dc_q;

    assign ic_rdata = owner_dc_q ? '0 : mem_rdata;
    assign dc_rdata = owner_dc_q ? mem_rdata : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q     <= 1'b0;
            owner_dc_q <= 1'b0;
        end else begin
            if (!busy_q) begin
                if (ic_valid || dc_valid) begin
                    busy_q     <= 1'b1;
                    owner_dc_q <= dc_valid;
                end
            end else if (mem_data_ok) begin
                busy_q <= 1'b0;   // free again after the response
            end
        end
    end

endmodule

/* project.f */
hdl/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/mem_arbiter.sv
hdl/cache_subsystem.sv
bench/cache_subsystem_asserts.sv
bench/tb_cache_subsystem.sv
